// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controllerTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/branchCondEval.sv ====
`timescale 1ns/1ps

module branchCondEval (
    input  logic [3:0]                  cond,
    input  logic [isaPkg::psrWidth-1:0] psr,
    output logic                        taken
);

    logic z, l, c, n, f;

    assign z = psr[isaPkg::flagZero];
    assign l = psr[isaPkg::flagLow];
    assign c = psr[isaPkg::flagCarry];
    assign n = psr[isaPkg::flagNeg];
    assign f = psr[isaPkg::flagFlag];

    always_comb
    begin
        case (cond)
            isaPkg::condEq: taken = z;
            isaPkg::condNe: taken = !z;
            isaPkg::condGe: taken = z || l;
            isaPkg::condCs: taken = c;
            isaPkg::condCc: taken = !c;
            isaPkg::condHi: taken = n;
            isaPkg::condLs: taken = !n;
            isaPkg::condLo: taken = !n && !z;
            isaPkg::condHs: taken = n || z;
            isaPkg::condGt: taken = l;
            isaPkg::condLe: taken = !l;
            isaPkg::condFs: taken = f;
            isaPkg::condFc: taken = !f;
            isaPkg::condLt: taken = !l && !z;
            isaPkg::condUc: taken = 1'b1;
            default:        taken = 1'b0; // never
        endcase
    end

endmodule

// ==== hdl/controlGen.sv ====
`timescale 1ns/1ps

module controlGen (
    input  logic [ctrlPkg::stateWidth-1:0] state,
    input  logic [ctrlPkg::classWidth-1:0] instrClass,
    input  logic                           taken,
    ctrlIf.gen                             ctrl
);

    logic immForm;

    assign immForm = (instrClass == ctrlPkg::clsAluImm) ||
                     (instrClass == ctrlPkg::clsCmpImm) ||
                     (instrClass == ctrlPkg::clsMovImm);

    always_comb
    begin
        ctrl.memWrite          = 1'b0;
        ctrl.pcEn              = 1'b0;
        ctrl.writeBackSelect   = 1'b0;
        ctrl.dataToWriteSelect = 1'b0;
        ctrl.newAluInput       = 1'b0;
        ctrl.psrRegEn          = 1'b0;
        ctrl.sendPcAddr        = 1'b0;
        ctrl.regWrite          = 1'b0;
        ctrl.instrWrite        = 1'b0;
        ctrl.aluSrc1Sel        = ctrlPkg::srcRegA;
        ctrl.aluSrc2Sel        = ctrlPkg::srcRegB;
        ctrl.pcSrc             = ctrlPkg::pcNext;
        case (state)
            ctrlPkg::stFetch: ctrl.instrWrite = 1'b1;
            ctrlPkg::stLoadRegs, ctrlPkg::stStoreRegs: ctrl.newAluInput = 1'b1;
            ctrlPkg::stAluEx, ctrlPkg::stCmpEx:
            begin
                ctrl.aluSrc1Sel = ctrlPkg::srcAluA;
                ctrl.aluSrc2Sel = immForm ? ctrlPkg::srcImm : ctrlPkg::srcRegB;
                ctrl.psrRegEn   = (state == ctrlPkg::stCmpEx); // CMP and CMPI alike
            end
            ctrlPkg::stMovEx:
            begin
                ctrl.aluSrc1Sel = ctrlPkg::srcZero; // 0 + src
                ctrl.aluSrc2Sel = immForm ? ctrlPkg::srcImm : ctrlPkg::srcRegB;
            end
            ctrlPkg::stWriteback: ctrl.regWrite = 1'b1;
            ctrlPkg::stMemWrite:  ctrl.memWrite = 1'b1;
            ctrlPkg::stLoadWb:
            begin
                ctrl.writeBackSelect = 1'b1;
                ctrl.regWrite        = 1'b1;
            end
            ctrlPkg::stJalStorePc:
            begin
                ctrl.dataToWriteSelect = 1'b1; // link address into rDest
                ctrl.regWrite          = 1'b1;
            end
            ctrlPkg::stJalNewPc:
            begin
                ctrl.pcSrc = ctrlPkg::pcAbs;
                ctrl.pcEn  = 1'b1;
            end
            ctrlPkg::stJump:
            begin
                ctrl.pcSrc = taken ? ctrlPkg::pcAbs : ctrlPkg::pcNext;
                ctrl.pcEn  = 1'b1;
            end
            ctrlPkg::stBranch:
            begin
                ctrl.pcSrc = taken ? ctrlPkg::pcRel : ctrlPkg::pcNext;
                ctrl.pcEn  = 1'b1;
            end
            ctrlPkg::stPcIncr:  ctrl.pcEn = 1'b1;
            ctrlPkg::stPcIncr3: ctrl.sendPcAddr = 1'b1; // address out ahead of fetch
            default: ctrl.pcEn = 1'b0;
        endcase
    end

endmodule

// ==== hdl/controller.sv ====
`timescale 1ns/1ps

module controller (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [15:0]                 instr,
    input  logic [isaPkg::psrWidth-1:0] psr,
    output logic                        memWrite,
    output logic                        pcEn,
    output logic                        writeBackSelect,
    output logic                        dataToWriteSelect,
    output logic                        newAluInput,
    output logic                        psrRegEn,
    output logic                        sendPcAddr,
    output logic                        regWrite,
    output logic                        instrWrite,
    output logic [1:0]                  aluSrc1Sel,
    output logic [1:0]                  aluSrc2Sel,
    output logic [1:0]                  pcSrc
);

    logic [ctrlPkg::classWidth-1:0] instrClass;
    logic [ctrlPkg::stateWidth-1:0] state;
    logic [3:0]                     cond;
    logic                           taken;

    ctrlIf ctrlBus ();

    instrDecoder u_decoder (
        .instr      (instr),
        .instrClass (instrClass),
        .cond       (cond)
    );

    branchCondEval u_condEval (
        .cond  (cond),
        .psr   (psr),
        .taken (taken)
    );

    sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state)
    );

    controlGen u_controlGen (
        .state      (state),
        .instrClass (instrClass),
        .taken      (taken),
        .ctrl       (ctrlBus.gen)
    );

    // flatten the bundle onto the datapath ports
    assign memWrite          = ctrlBus.memWrite;
    assign pcEn              = ctrlBus.pcEn;
    assign writeBackSelect   = ctrlBus.writeBackSelect;
    assign dataToWriteSelect = ctrlBus.dataToWriteSelect;
    assign newAluInput       = ctrlBus.newAluInput;
    assign psrRegEn          = ctrlBus.psrRegEn;
    assign sendPcAddr        = ctrlBus.sendPcAddr;
    assign regWrite          = ctrlBus.regWrite;
    assign instrWrite        = ctrlBus.instrWrite;
    assign aluSrc1Sel        = ctrlBus.aluSrc1Sel;
    assign aluSrc2Sel        = ctrlBus.aluSrc2Sel;
    assign pcSrc             = ctrlBus.pcSrc;

endmodule

// ==== hdl/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf;
    logic       memWrite;
    logic       pcEn;
    logic       writeBackSelect;   // 1 selects memory data
    logic       dataToWriteSelect; // 1 selects return pc for JAL
    logic       newAluInput;
    logic       psrRegEn;
    logic       sendPcAddr;
    logic       regWrite;
    logic       instrWrite;
    logic [1:0] aluSrc1Sel;
    logic [1:0] aluSrc2Sel;
    logic [1:0] pcSrc;

    modport gen (
        output memWrite, pcEn, writeBackSelect, dataToWriteSelect, newAluInput,
        output psrRegEn, sendPcAddr, regWrite, instrWrite,
        output aluSrc1Sel, aluSrc2Sel, pcSrc
    );

    modport sink (
        input memWrite, pcEn, writeBackSelect, dataToWriteSelect, newAluInput,
        input psrRegEn, sendPcAddr, regWrite, instrWrite,
        input aluSrc1Sel, aluSrc2Sel, pcSrc
    );
endinterface

// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

    localparam int stateWidth = 5;

    localparam logic [stateWidth-1:0] stFetch      = 5'd0;
    localparam logic [stateWidth-1:0] stDecode     = 5'd1;
    localparam logic [stateWidth-1:0] stLoadRegs   = 5'd2;
    localparam logic [stateWidth-1:0] stAluEx      = 5'd3;
    localparam logic [stateWidth-1:0] stWriteback  = 5'd4;
    localparam logic [stateWidth-1:0] stCmpEx      = 5'd5;
    localparam logic [stateWidth-1:0] stMovEx      = 5'd6;
    localparam logic [stateWidth-1:0] stMemRead    = 5'd7;
    localparam logic [stateWidth-1:0] stMemWrite   = 5'd8;
    localparam logic [stateWidth-1:0] stLoadWb     = 5'd9;
    localparam logic [stateWidth-1:0] stStoreRegs  = 5'd10;
    localparam logic [stateWidth-1:0] stJalStorePc = 5'd11;
    localparam logic [stateWidth-1:0] stJalNewPc   = 5'd12;
    localparam logic [stateWidth-1:0] stJump       = 5'd13;
    localparam logic [stateWidth-1:0] stBranch     = 5'd14;
    localparam logic [stateWidth-1:0] stPcIncr     = 5'd15;
    localparam logic [stateWidth-1:0] stPcIncr2    = 5'd16;
    localparam logic [stateWidth-1:0] stPcIncr3    = 5'd17;

    localparam int classWidth = 4;

    localparam logic [classWidth-1:0] clsAlu    = 4'd0;
    localparam logic [classWidth-1:0] clsAluImm = 4'd1;
    localparam logic [classWidth-1:0] clsCmp    = 4'd2;
    localparam logic [classWidth-1:0] clsCmpImm = 4'd3;
    localparam logic [classWidth-1:0] clsMov    = 4'd4;
    localparam logic [classWidth-1:0] clsMovImm = 4'd5;
    localparam logic [classWidth-1:0] clsLoad   = 4'd6;
    localparam logic [classWidth-1:0] clsStore  = 4'd7;
    localparam logic [classWidth-1:0] clsJal    = 4'd8;
    localparam logic [classWidth-1:0] clsJump   = 4'd9;
    localparam logic [classWidth-1:0] clsBranch = 4'd10;
    localparam logic [classWidth-1:0] clsNone   = 4'd11; // undefined or never-taken

    // aluSrc1Sel
    localparam logic [1:0] srcRegA = 2'd0;
    localparam logic [1:0] srcAluA = 2'd1;
    localparam logic [1:0] srcZero = 2'd2;

    // aluSrc2Sel
    localparam logic [1:0] srcRegB = 2'd0;
    localparam logic [1:0] srcImm  = 2'd1;

    // pcSrc
    localparam logic [1:0] pcNext = 2'd0;
    localparam logic [1:0] pcAbs  = 2'd1; // jump target from register
    localparam logic [1:0] pcRel  = 2'd2; // pc plus displacement

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  isaPkg::instrWord               instr,
    output logic [ctrlPkg::classWidth-1:0] instrClass,
    output logic [3:0]                     cond
);

    logic isJcond;
    logic isBcond;
    logic never;

    assign isJcond = (instr.regForm.op == isaPkg::opMem) &&
                     (instr.regForm.opExt == isaPkg::extJcond);
    assign isBcond = (instr.brForm.op == isaPkg::opBcond);
    assign never   = (instr.brForm.cond == isaPkg::condNever);

    // non-branch words force the never code so taken stays low
    assign cond = (isJcond || isBcond) ? instr.brForm.cond : isaPkg::condNever;

    always_comb
    begin
        instrClass = ctrlPkg::clsNone;
        case (instr.regForm.op)
            isaPkg::opRegOps:
                case (instr.regForm.opExt)
                    isaPkg::extAdd, isaPkg::extSub, isaPkg::extAnd,
                    isaPkg::extOr, isaPkg::extXor, isaPkg::extMul:
                        instrClass = ctrlPkg::clsAlu;
                    isaPkg::extCmp: instrClass = ctrlPkg::clsCmp;
                    isaPkg::extMov: instrClass = ctrlPkg::clsMov;
                    default: instrClass = ctrlPkg::clsNone;
                endcase
            isaPkg::opShift:
                if (instr.regForm.opExt == isaPkg::extLsh)
                    instrClass = ctrlPkg::clsAlu;
                else
                    instrClass = ctrlPkg::clsAluImm; // LSHI
            isaPkg::opMem:
                case (instr.regForm.opExt)
                    isaPkg::extLoad: instrClass = ctrlPkg::clsLoad;
                    isaPkg::extStor: instrClass = ctrlPkg::clsStore;
                    isaPkg::extJal:  instrClass = ctrlPkg::clsJal;
                    isaPkg::extJcond:
                        instrClass = never ? ctrlPkg::clsNone : ctrlPkg::clsJump;
                    default: instrClass = ctrlPkg::clsNone;
                endcase
            isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opAddi,
            isaPkg::opModi, isaPkg::opSubi, isaPkg::opLui:
                instrClass = ctrlPkg::clsAluImm;
            isaPkg::opCmpi: instrClass = ctrlPkg::clsCmpImm;
            isaPkg::opMovi: instrClass = ctrlPkg::clsMovImm;
            isaPkg::opBcond:
                instrClass = never ? ctrlPkg::clsNone : ctrlPkg::clsBranch;
            default: instrClass = ctrlPkg::clsNone;
        endcase
    end

endmodule

// ==== hdl/isaPkg.sv ====
package isaPkg;

    // register view: op | rDest | opExt | rSrc
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] rDest;
        logic [3:0] opExt;
        logic [3:0] rSrc;
    } regFormT;

    // branch view, cond overlays rDest
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] cond;
        logic [7:0] disp;
    } brFormT;

    typedef union packed {
        regFormT regForm;
        brFormT  brForm;
    } instrWord;

    localparam logic [3:0] opRegOps = 4'b0000;
    localparam logic [3:0] opAndi   = 4'b0001;
    localparam logic [3:0] opOri    = 4'b0010;
    localparam logic [3:0] opXori   = 4'b0011;
    localparam logic [3:0] opMem    = 4'b0100;
    localparam logic [3:0] opAddi   = 4'b0101;
    localparam logic [3:0] opModi   = 4'b0110;
    localparam logic [3:0] opShift  = 4'b1000;
    localparam logic [3:0] opSubi   = 4'b1001;
    localparam logic [3:0] opCmpi   = 4'b1011;
    localparam logic [3:0] opBcond  = 4'b1100;
    localparam logic [3:0] opMovi   = 4'b1101;
    localparam logic [3:0] opLui    = 4'b1111;

    // opExt under opRegOps
    localparam logic [3:0] extAnd = 4'b0001;
    localparam logic [3:0] extOr  = 4'b0010;
    localparam logic [3:0] extXor = 4'b0011;
    localparam logic [3:0] extAdd = 4'b0101;
    localparam logic [3:0] extSub = 4'b1001;
    localparam logic [3:0] extCmp = 4'b1011;
    localparam logic [3:0] extMov = 4'b1101;
    localparam logic [3:0] extMul = 4'b1110;

    localparam logic [3:0] extLsh = 4'b0100; // any other opExt under opShift is LSHI

    // opExt under opMem
    localparam logic [3:0] extLoad  = 4'b0000;
    localparam logic [3:0] extStor  = 4'b0100;
    localparam logic [3:0] extJal   = 4'b1000;
    localparam logic [3:0] extJcond = 4'b1100;

    localparam logic [3:0] condEq    = 4'b0000;
    localparam logic [3:0] condNe    = 4'b0001;
    localparam logic [3:0] condCs    = 4'b0010;
    localparam logic [3:0] condCc    = 4'b0011;
    localparam logic [3:0] condHi    = 4'b0100;
    localparam logic [3:0] condLs    = 4'b0101;
    localparam logic [3:0] condGt    = 4'b0110;
    localparam logic [3:0] condLe    = 4'b0111;
    localparam logic [3:0] condFs    = 4'b1000;
    localparam logic [3:0] condFc    = 4'b1001;
    localparam logic [3:0] condLo    = 4'b1010;
    localparam logic [3:0] condHs    = 4'b1011;
    localparam logic [3:0] condLt    = 4'b1100;
    localparam logic [3:0] condGe    = 4'b1101;
    localparam logic [3:0] condUc    = 4'b1110;
    localparam logic [3:0] condNever = 4'b1111;

    // psr bit positions
    localparam int flagLow   = 0;
    localparam int flagZero  = 1;
    localparam int flagFlag  = 2;
    localparam int flagNeg   = 3;
    localparam int flagCarry = 4;

    localparam int psrWidth = 8;

endpackage

// ==== hdl/sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [ctrlPkg::classWidth-1:0] instrClass,
    output logic [ctrlPkg::stateWidth-1:0] state
);

    logic [ctrlPkg::stateWidth-1:0] nextState;

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= ctrlPkg::stFetch;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = ctrlPkg::stFetch;
        case (state)
            ctrlPkg::stFetch: nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode:
                case (instrClass)
                    ctrlPkg::clsAlu, ctrlPkg::clsAluImm, ctrlPkg::clsCmp,
                    ctrlPkg::clsCmpImm, ctrlPkg::clsMov, ctrlPkg::clsMovImm,
                    ctrlPkg::clsLoad, ctrlPkg::clsJal:
                        nextState = ctrlPkg::stLoadRegs;
                    ctrlPkg::clsStore:  nextState = ctrlPkg::stStoreRegs;
                    ctrlPkg::clsJump:   nextState = ctrlPkg::stJump;
                    ctrlPkg::clsBranch: nextState = ctrlPkg::stBranch;
                    ctrlPkg::clsNone:   nextState = ctrlPkg::stPcIncr;
                    default:            nextState = ctrlPkg::stPcIncr;
                endcase
            // shared operand load, split by class afterwards
            ctrlPkg::stLoadRegs:
                case (instrClass)
                    ctrlPkg::clsCmp, ctrlPkg::clsCmpImm: nextState = ctrlPkg::stCmpEx;
                    ctrlPkg::clsMov, ctrlPkg::clsMovImm: nextState = ctrlPkg::stMovEx;
                    ctrlPkg::clsLoad:                    nextState = ctrlPkg::stMemRead;
                    ctrlPkg::clsJal:                     nextState = ctrlPkg::stJalStorePc;
                    default:                             nextState = ctrlPkg::stAluEx;
                endcase
            ctrlPkg::stAluEx:      nextState = ctrlPkg::stWriteback;
            ctrlPkg::stMovEx:      nextState = ctrlPkg::stWriteback;
            ctrlPkg::stWriteback:  nextState = ctrlPkg::stPcIncr;
            ctrlPkg::stCmpEx:      nextState = ctrlPkg::stPcIncr; // flags only, no writeback
            ctrlPkg::stMemRead:    nextState = ctrlPkg::stLoadWb;
            ctrlPkg::stLoadWb:     nextState = ctrlPkg::stPcIncr;
            ctrlPkg::stStoreRegs:  nextState = ctrlPkg::stMemWrite;
            ctrlPkg::stMemWrite:   nextState = ctrlPkg::stPcIncr;
            ctrlPkg::stJalStorePc: nextState = ctrlPkg::stJalNewPc;
            ctrlPkg::stJalNewPc:   nextState = ctrlPkg::stPcIncr;
            ctrlPkg::stJump:       nextState = ctrlPkg::stPcIncr2; // pc already written
            ctrlPkg::stBranch:     nextState = ctrlPkg::stPcIncr2;
            ctrlPkg::stPcIncr:     nextState = ctrlPkg::stPcIncr2;
            ctrlPkg::stPcIncr2:    nextState = ctrlPkg::stPcIncr3;
            ctrlPkg::stPcIncr3:    nextState = ctrlPkg::stFetch;
            default:               nextState = ctrlPkg::stFetch;
        endcase
    end

endmodule

// ==== project.f ====
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/ctrlIf.sv
hdl/instrDecoder.sv
hdl/branchCondEval.sv
hdl/sequencer.sv
hdl/controlGen.sv
hdl/controller.sv
tb/controller_checker.sv
tb/controllerTb.sv

// ==== tb/controllerTb.sv ====
`timescale 1ns/1ps

module controllerTb;

    localparam int numInstr  = 400;
    localparam int maxCycles = numInstr * 8 + 50; // longest class is 8 cycles

    localparam logic [14:0] mMemWrite   = 15'h4000;
    localparam logic [14:0] mPcEn       = 15'h2000;
    localparam logic [14:0] mWbSel      = 15'h1000;
    localparam logic [14:0] mDataSel    = 15'h0800;
    localparam logic [14:0] mNewAlu     = 15'h0400;
    localparam logic [14:0] mPsrEn      = 15'h0200;
    localparam logic [14:0] mSendPc     = 15'h0100;
    localparam logic [14:0] mRegWrite   = 15'h0080;
    localparam logic [14:0] mInstrWrite = 15'h0040;

    localparam logic [3:0] regExtTab [8] = '{isaPkg::extAdd, isaPkg::extSub, isaPkg::extCmp,
        isaPkg::extAnd, isaPkg::extOr, isaPkg::extXor, isaPkg::extMov, isaPkg::extMul};
    localparam logic [3:0] immOpTab [8] = '{isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori,
        isaPkg::opAddi, isaPkg::opModi, isaPkg::opSubi, isaPkg::opLui, isaPkg::opAddi};
    localparam logic [3:0] memExtTab [4] = '{isaPkg::extLoad, isaPkg::extStor,
        isaPkg::extJal, isaPkg::extJcond};

    logic        clk;
    logic        reset;
    logic [15:0] instr;
    logic [7:0]  psr;
    logic        memWrite, pcEn, writeBackSelect, dataToWriteSelect, newAluInput;
    logic        psrRegEn, sendPcAddr, regWrite, instrWrite;
    logic [1:0]  aluSrc1Sel, aluSrc2Sel, pcSrc;
    logic [14:0] got;
    logic [14:0] expQ [$];  // expected lines from decode to PcIncr3
    integer      seed;
    int          cycleCount = 0;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          failedTests = 0;

    controller u_dut (
        .clk               (clk),
        .reset             (reset),
        .instr             (instr),
        .psr               (psr),
        .memWrite          (memWrite),
        .pcEn              (pcEn),
        .writeBackSelect   (writeBackSelect),
        .dataToWriteSelect (dataToWriteSelect),
        .newAluInput       (newAluInput),
        .psrRegEn          (psrRegEn),
        .sendPcAddr        (sendPcAddr),
        .regWrite          (regWrite),
        .instrWrite        (instrWrite),
        .aluSrc1Sel        (aluSrc1Sel),
        .aluSrc2Sel        (aluSrc2Sel),
        .pcSrc             (pcSrc)
    );

    bind controller controllerChecker u_checker (
        .clk        (clk),
        .reset      (reset),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .psrRegEn   (psrRegEn),
        .instrWrite (instrWrite),
        .sendPcAddr (sendPcAddr)
    );

    assign got = {memWrite, pcEn, writeBackSelect, dataToWriteSelect, newAluInput, psrRegEn,
                  sendPcAddr, regWrite, instrWrite, aluSrc1Sel, aluSrc2Sel, pcSrc};

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= maxCycles)
        begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [14:0] sel(input logic [1:0] s1, input logic [1:0] s2,
                                        input logic [1:0] ps);
        return {9'b0, s1, s2, ps};
    endfunction

    // class from the op/opExt/cond rules of the ISA
    function automatic logic [3:0] expectedClass(input logic [15:0] w);
        logic [3:0] op;
        logic [3:0] ext;
        logic [3:0] cnd;
        op  = w[15:12];
        ext = w[7:4];
        cnd = w[11:8];
        if (op == isaPkg::opRegOps)
        begin
            if (ext == isaPkg::extCmp)
                return ctrlPkg::clsCmp;
            if (ext == isaPkg::extMov)
                return ctrlPkg::clsMov;
            if (ext inside {isaPkg::extAdd, isaPkg::extSub, isaPkg::extAnd, isaPkg::extOr,
                            isaPkg::extXor, isaPkg::extMul})
                return ctrlPkg::clsAlu;
            return ctrlPkg::clsNone;
        end
        if (op == isaPkg::opShift)
            return (ext == isaPkg::extLsh) ? ctrlPkg::clsAlu : ctrlPkg::clsAluImm;
        if (op inside {isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opAddi,
                       isaPkg::opModi, isaPkg::opSubi, isaPkg::opLui})
            return ctrlPkg::clsAluImm;
        if (op == isaPkg::opCmpi)
            return ctrlPkg::clsCmpImm;
        if (op == isaPkg::opMovi)
            return ctrlPkg::clsMovImm;
        if (op == isaPkg::opBcond)
            return (cnd == isaPkg::condNever) ? ctrlPkg::clsNone : ctrlPkg::clsBranch;
        if (op == isaPkg::opMem)
        begin
            if (ext == isaPkg::extLoad)
                return ctrlPkg::clsLoad;
            if (ext == isaPkg::extStor)
                return ctrlPkg::clsStore;
            if (ext == isaPkg::extJal)
                return ctrlPkg::clsJal;
            if (ext == isaPkg::extJcond && cnd != isaPkg::condNever)
                return ctrlPkg::clsJump;
        end
        return ctrlPkg::clsNone;
    endfunction

    function automatic logic takenRef(input logic [3:0] c, input logic [7:0] p);
        logic z;
        logic l;
        logic cy;
        logic ng;
        logic f;
        z  = p[isaPkg::flagZero];
        l  = p[isaPkg::flagLow];
        cy = p[isaPkg::flagCarry];
        ng = p[isaPkg::flagNeg];
        f  = p[isaPkg::flagFlag];
        case (c)
            isaPkg::condEq: return z;
            isaPkg::condNe: return !z;
            isaPkg::condGe: return z | l;
            isaPkg::condCs: return cy;
            isaPkg::condCc: return !cy;
            isaPkg::condHi: return ng;
            isaPkg::condLs: return !ng;
            isaPkg::condLo: return !ng & !z;
            isaPkg::condHs: return ng | z;
            isaPkg::condGt: return l;
            isaPkg::condLe: return !l;
            isaPkg::condFs: return f;
            isaPkg::condFc: return !f;
            isaPkg::condLt: return !l & !z;
            isaPkg::condUc: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic nextInstr(output logic [15:0] w);
        logic [31:0] r;
        logic [3:0]  pick;
        logic [2:0]  sub;
        r = $random(seed);
        w = r[15:0];           // register and cond fields stay random
        r = $random(seed);
        pick = r[3:0];
        sub  = r[6:4];
        case (pick)
            4'd0, 4'd1:
            begin
                w[15:12] = isaPkg::opRegOps;
                w[7:4]   = regExtTab[sub];
            end
            4'd2: w[15:12] = isaPkg::opRegOps; // any opExt, undefined ones too
            4'd3: w[15:12] = isaPkg::opShift;
            4'd4, 4'd5: w[15:12] = immOpTab[sub];
            4'd6: w[15:12] = isaPkg::opCmpi;
            4'd7: w[15:12] = isaPkg::opMovi;
            4'd8, 4'd9, 4'd10, 4'd11:
            begin
                w[15:12] = isaPkg::opMem;
                w[7:4]   = memExtTab[sub[1:0]];
            end
            4'd12, 4'd13: w[15:12] = isaPkg::opBcond;
            default: ; // whole word random
        endcase
    endtask

    task automatic buildExpected(input logic [3:0] cls, input logic tk);
        logic [1:0] src2;
        src2 = (cls == ctrlPkg::clsAluImm || cls == ctrlPkg::clsCmpImm ||
                cls == ctrlPkg::clsMovImm) ? ctrlPkg::srcImm : ctrlPkg::srcRegB;
        expQ.delete();
        expQ.push_back(15'h0000); // decode
        case (cls)
            ctrlPkg::clsAlu, ctrlPkg::clsAluImm:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(sel(ctrlPkg::srcAluA, src2, ctrlPkg::pcNext));
                expQ.push_back(mRegWrite);
            end
            ctrlPkg::clsMov, ctrlPkg::clsMovImm:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(sel(ctrlPkg::srcZero, src2, ctrlPkg::pcNext));
                expQ.push_back(mRegWrite);
            end
            ctrlPkg::clsCmp, ctrlPkg::clsCmpImm:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(mPsrEn | sel(ctrlPkg::srcAluA, src2, ctrlPkg::pcNext));
            end
            ctrlPkg::clsLoad:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(15'h0000); // memory read cycle
                expQ.push_back(mWbSel | mRegWrite);
            end
            ctrlPkg::clsStore:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(mMemWrite);
            end
            ctrlPkg::clsJal:
            begin
                expQ.push_back(mNewAlu);
                expQ.push_back(mDataSel | mRegWrite);
                expQ.push_back(mPcEn | sel(ctrlPkg::srcRegA, ctrlPkg::srcRegB, ctrlPkg::pcAbs));
            end
            ctrlPkg::clsJump:
                expQ.push_back(mPcEn | sel(ctrlPkg::srcRegA, ctrlPkg::srcRegB,
                                           tk ? ctrlPkg::pcAbs : ctrlPkg::pcNext));
            ctrlPkg::clsBranch:
                expQ.push_back(mPcEn | sel(ctrlPkg::srcRegA, ctrlPkg::srcRegB,
                                           tk ? ctrlPkg::pcRel : ctrlPkg::pcNext));
            default: ;
        endcase
        if (cls != ctrlPkg::clsJump && cls != ctrlPkg::clsBranch)
            expQ.push_back(mPcEn); // first pc increment
        expQ.push_back(15'h0000);
        expQ.push_back(mSendPc);
    endtask

    task automatic compareField(input string name, input logic [1:0] gotV,
                                input logic [1:0] expV, input string step);
        assert (gotV === expV)
        else
        begin
            $display("Mismatch %s at %s: got 0x%h, expected 0x%h", name, step, gotV, expV);
            testErrors++;
        end
    endtask

    task automatic checkLines(input logic [14:0] e, input string step);
        compareField("memWrite", {1'b0, got[14]}, {1'b0, e[14]}, step);
        compareField("pcEn", {1'b0, got[13]}, {1'b0, e[13]}, step);
        compareField("writeBackSelect", {1'b0, got[12]}, {1'b0, e[12]}, step);
        compareField("dataToWriteSelect", {1'b0, got[11]}, {1'b0, e[11]}, step);
        compareField("newAluInput", {1'b0, got[10]}, {1'b0, e[10]}, step);
        compareField("psrRegEn", {1'b0, got[9]}, {1'b0, e[9]}, step);
        compareField("sendPcAddr", {1'b0, got[8]}, {1'b0, e[8]}, step);
        compareField("regWrite", {1'b0, got[7]}, {1'b0, e[7]}, step);
        compareField("instrWrite", {1'b0, got[6]}, {1'b0, e[6]}, step);
        compareField("aluSrc1Sel", got[5:4], e[5:4], step);
        compareField("aluSrc2Sel", got[3:2], e[3:2], step);
        compareField("pcSrc", got[1:0], e[1:0], step);
    endtask

    initial
    begin
        int          n;
        int          k;
        logic [15:0] word;
        logic [31:0] r;
        logic [3:0]  cls;
        logic        tk;
        seed  = 32'h0dda_118e;
        clk   = 1'b0;
        reset = 1'b0;
        instr = 16'h0000;
        psr   = 8'h00;

        repeat (4) @(posedge clk);
        @(negedge clk);
        checkLines(mInstrWrite, "reset");
        @(posedge clk);
        #1 reset = 1'b1;
        $display("reset: %s", testErrors == 0 ? "ok" : "errors");
        totalErrors += testErrors;
        if (testErrors != 0)
            failedTests++;

        for (n = 0; n < numInstr; n++)
        begin
            testErrors = 0;
            @(negedge clk);
            checkLines(mInstrWrite, $sformatf("instr %0d fetch", n));
            @(posedge clk);
            #1;
            nextInstr(word);
            r = $random(seed);
            instr = word;
            psr   = r[7:0];
            cls = expectedClass(word);
            tk  = takenRef(word[11:8], r[7:0]);
            buildExpected(cls, tk);
            for (k = 0; k < expQ.size(); k++)
            begin
                @(negedge clk);
                checkLines(expQ[k], $sformatf("instr %0d cycle %0d", n, k + 2));
            end
            $display("instr %0d: word 0x%h psr 0x%h class %0d, %0d cycles, %s", n, word,
                     r[7:0], cls, expQ.size() + 1, testErrors == 0 ? "ok" : "errors");
            totalErrors += testErrors;
            if (testErrors != 0)
                failedTests++;
        end

        $display("%0d tests, %0d failed, %0d check errors, %0d checker errors", numInstr + 1,
                 failedTests, totalErrors, u_dut.u_checker.failCount);
        if (totalErrors == 0 && u_dut.u_checker.failCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== tb/controller_checker.sv ====
`timescale 1ns/1ps

module controllerChecker (
    input logic clk,
    input logic reset,
    input logic regWrite,
    input logic memWrite,
    input logic psrRegEn,
    input logic instrWrite,
    input logic sendPcAddr
);

    int failCount = 0; // read by the testbench at the end of the run

    noRegMemWrite: assert property (@(posedge clk) disable iff (!reset)
        !(regWrite && memWrite))
    else
    begin
        failCount++;
        $error("regWrite and memWrite high in the same cycle");
    end

    // one fetch per instruction
    noFetchRepeat: assert property (@(posedge clk) disable iff (!reset)
        instrWrite |=> !instrWrite)
    else
    begin
        failCount++;
        $error("instrWrite high on two consecutive cycles");
    end

    fetchAfterPcAddr: assert property (@(posedge clk) disable iff (!reset)
        sendPcAddr |=> instrWrite)
    else
    begin
        failCount++;
        $error("sendPcAddr not followed by instrWrite");
    end

    noFlagsWithWrite: assert property (@(posedge clk) disable iff (!reset)
        !(psrRegEn && regWrite))
    else
    begin
        failCount++;
        $error("psrRegEn and regWrite high in the same cycle");
    end

endmodule
